/* bench/ring_lsu_sva.sv */
`timescale 1ns/1ps

module ring_lsu_sva #(
    parameter int NUM_THREADS = 8
)
(
    input logic                   clk,
    input logic                   rst_n,
    input logic                   req_valid,
    input logic                   req_ready,
    input lsu_pkg::lsu_req_t      req,
    input logic                   load_valid,
    input logic                   load_ready,
    input lsu_pkg::lsu_load_t     load,
    input logic [NUM_THREADS-1:0] stall,
    input logic                   fwd_valid,
    input logic                   back_valid
);

    localparam int TID_W = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1;

    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("Request dropped or changed before its transfer");

    load_hold: assert property (@(posedge clk) disable iff (!rst_n)
        load_valid && !load_ready |=> load_valid && $stable(load))
        else $error("Load dropped or changed while waiting");

    stalled_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        stall[req.thread[TID_W-1:0]] |-> !req_ready)
        else $error("req_ready high for a stalled thread");

    // Both hops of the loop come out of reset empty
    ring_quiet: assert property (@(posedge clk)
        !rst_n |=> !fwd_valid && !back_valid)
        else $error("Ring slot valid during reset");

endmodule

bind ring_lsu_top ring_lsu_sva #(.NUM_THREADS(NUM_THREADS)) u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .load_valid (load_valid),
    .load_ready (load_ready),
    .load       (load),
    .stall      (stall),
    .fwd_valid  (ring_m2s.valid),
    .back_valid (ring_s2m.valid)
);

/* bench/tb_ring_lsu.sv */
`timescale 1ns/1ps

module tb_ring_lsu;
    import ring_pkg::*;
    import lsu_pkg::*;

    localparam int NUM_THREADS = 8;
    localparam int MEM_WORDS   = 256;
    localparam int NUM_RANDOM  = 300;
    localparam int NUM_REQS    = MEM_WORDS + NUM_RANDOM;
    localparam int CYCLE_LIMIT = NUM_REQS * 40;
    localparam int CLK_PERIOD  = 100;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    logic                   req_ready;
    lsu_req_t               req;
    logic                   load_valid;
    logic                   load_ready;
    lsu_load_t              load;
    logic [NUM_THREADS-1:0] stall;

    int                     seed;
    int                     cycles;
    int                     sent;
    int                     hold_low;
    logic [31:0]            mem_model [MEM_WORDS];
    logic [NUM_THREADS-1:0] busy;
    lsu_load_t              exp_q [$];
    logic                   req_fire;
    logic                   load_fire;
    lsu_load_t              load_seen;
    logic                   load_held;
    lsu_load_t              held_load;

    ring_lsu_top #(
        .NUM_THREADS (NUM_THREADS),
        .MASTER_ID   (0),
        .MEM_WORDS   (MEM_WORDS)
    ) u_ring_lsu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load       (load),
        .stall      (stall)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("ERR %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            abort_run($sformatf("Timeout: requests still open after %0d cycles", CYCLE_LIMIT));
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Preload pattern built from every index bit
    function automatic logic [31:0] fill_word(input int i);
        return {8'(i), 8'(~i), 8'(i * 7 + 3), 8'(i) ^ 8'hc3};
    endfunction

    function automatic ring_mask_t pick_mask();
        int r;
        r = rand_below(7);
        if (r == 0)
            return 4'b1111;
        else if (r == 1)
            return 4'b1100;
        else if (r == 2)
            return 4'b0011;
        return 4'(1 << (r - 3));
    endfunction

    // Half the time one of a few low words in either alias
    function automatic int pick_addr();
        if (rand_below(2) == 0)
            return rand_below(16) + 256 * rand_below(2);
        return rand_below(512);
    endfunction

    // Lane position and width from the mask priority, then shift down
    function automatic logic [31:0] expect_lane(input logic [3:0] mask, input logic [31:0] word);
        int          lo;
        int          nbytes;
        logic [31:0] keep;
        lo = 0;
        nbytes = 1;
        if (mask == 4'b1111)
            nbytes = 4;
        else if (mask[3] && mask[2])
        begin
            lo = 2;
            nbytes = 2;
        end
        else if (mask[1] && mask[0])
            nbytes = 2;
        else
        begin
            for (int b = 0; b < 4; b++)
                if (mask[b])
                    lo = b;
        end
        keep = (nbytes == 4) ? 32'hffff_ffff : ((32'd1 << (8 * nbytes)) - 32'd1);
        return (word >> (8 * lo)) & keep;
    endfunction

    function automatic logic pending_work();
        return req_valid || (busy != '0) || (exp_q.size() != 0) || (sent < NUM_REQS);
    endfunction

    task automatic drive_inputs();
        int t;
        if (hold_low > 0)
        begin
            hold_low = hold_low - 1;
            load_ready = 1'b0;
        end
        else if (rand_below(60) == 0)
        begin
            hold_low = 20 + rand_below(30);
            load_ready = 1'b0;
        end
        else
            load_ready = (rand_below(10) >= 3);

        if (!req_valid && sent < NUM_REQS && rand_below(5) != 0)
        begin
            t = rand_below(NUM_THREADS);
            if (!stall[t])
            begin
                req_valid   = 1'b1;
                req.thread  = 5'(t);
                req.reg_idx = 3'(rand_below(8));
                if (sent < MEM_WORDS)
                begin
                    // Known contents first with one full-word write per word
                    req.wr   = 1'b1;
                    req.mask = 4'b1111;
                    req.addr = 24'(sent);
                    req.data = fill_word(sent);
                end
                else
                begin
                    req.wr   = (rand_below(2) == 1);
                    req.mask = pick_mask();
                    req.addr = 24'(pick_addr());
                    req.data = 32'($random(seed));
                end
            end
        end
    endtask

    // Runs shortly before the rising edge, when all outputs have settled
    task automatic sample_edge();
        if (load_held)
        begin
            check_value(64'(load_valid), 64'(1), "load_valid dropped while waiting");
            check_value(64'(load), 64'(held_load), "load changed while waiting");
        end
        load_held = load_valid && !load_ready;
        held_load = load;
        req_fire  = req_valid && req_ready;
        load_fire = load_valid && load_ready;
        load_seen = load;
    endtask

    task automatic process_edge();
        int        t;
        int        idx;
        int        found;
        lsu_load_t e;
        if (req_fire)
        begin
            t = int'(req.thread);
            idx = int'(req.addr) % MEM_WORDS;
            if (req.wr)
            begin
                for (int b = 0; b < 4; b++)
                    if (req.mask[b])
                        mem_model[idx][8*b +: 8] = req.data[8*b +: 8];
            end
            else
            begin
                e.thread  = req.thread;
                e.reg_idx = req.reg_idx;
                e.data    = expect_lane(req.mask, mem_model[idx]);
                exp_q.push_back(e);
            end
            check_value(64'(stall[t]), 64'(1), "stall bit after request transfer");
            busy[t] = 1'b1;
            req_valid = 1'b0;
            sent = sent + 1;
        end

        if (load_fire)
        begin
            found = -1;
            for (int i = 0; i < exp_q.size(); i++)
                if (found < 0 && exp_q[i].thread == load_seen.thread)
                    found = i;
            if (found < 0)
                abort_run($sformatf("Load for thread %0d with no read outstanding",
                                    load_seen.thread));
            else
            begin
                check_value(64'(load_seen.reg_idx), 64'(exp_q[found].reg_idx), "load reg_idx");
                check_value(64'(load_seen.data), 64'(exp_q[found].data), "load data");
                exp_q.delete(found);
            end
        end

        // A stall bit may only stand for a request still in flight
        for (int i = 0; i < NUM_THREADS; i++)
        begin
            if (busy[i] && !stall[i])
                busy[i] = 1'b0;
            else if (!busy[i])
                check_value(64'(stall[i]), 64'(0), "stall bit without a request");
        end
    endtask

    initial
    begin
        seed       = 9805;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        load_ready = 1'b0;
        busy       = '0;
        sent       = 0;
        hold_low   = 0;
        load_held  = 1'b0;
        req_fire   = 1'b0;
        load_fire  = 1'b0;
        load_seen  = '0;
        held_load  = '0;

        repeat (8) @(negedge clk);
        check_value(64'(req_ready), 64'(0), "req_ready in reset");
        check_value(64'(load_valid), 64'(0), "load_valid in reset");
        check_value(64'(stall), 64'(0), "stall vector in reset");
        rst_n = 1'b1;

        while (pending_work())
        begin
            drive_inputs();
            #(CLK_PERIOD / 2 - 10);
            sample_edge();
            @(negedge clk);
            process_edge();
        end

        check_value(64'(load_valid), 64'(0), "load_valid at end");

        // Quiet tail after the last retire
        repeat (4)
        begin
            @(negedge clk);
            check_value(64'(stall), 64'(0), "stall vector at end");
            check_value(64'(load_valid), 64'(0), "load_valid at end");
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* ring_lsu_top.f */
verilog/ring_pkg.sv
verilog/lsu_pkg.sv
verilog/load_align.sv
verilog/lsu_skid_buffer.sv
verilog/lsu_tracker.sv
verilog/ring_master_node.sv
verilog/ring_memory_node.sv
verilog/ring_lsu_top.sv
bench/ring_lsu_sva.sv
bench/tb_ring_lsu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ring LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_ring_lsu \
    -f ring_lsu_top.f \
    --Mdir obj_dir \
    -o sim_tb_ring_lsu

./obj_dir/sim_tb_ring_lsu

/* verilog/load_align.sv */
`timescale 1ns/1ps

module load_align
(
    input  ring_pkg::ring_mask_t mask,
    input  ring_pkg::ring_data_t data,
    output ring_pkg::ring_data_t aligned
);

    // Full word wins, then the upper half, then the lower half,
    // otherwise the highest selected byte
    always_comb
    begin
        if (mask == 4'b1111)
        begin
            aligned = data;
        end
        else if (mask[3:2] == 2'b11)
        begin
            aligned = {16'd0, data[31:16]};
        end
        else if (mask[1:0] == 2'b11)
        begin
            aligned = {16'd0, data[15:0]};
        end
        else if (mask[3])
        begin
            aligned = {24'd0, data[31:24]};
        end
        else if (mask[2])
        begin
            aligned = {24'd0, data[23:16]};
        end
        else if (mask[1])
        begin
            aligned = {24'd0, data[15:8]};
        end
        else
        begin
            // Also covers an empty mask
            aligned = {24'd0, data[7:0]};
        end
    end

endmodule

/* verilog/lsu_pkg.sv */
package lsu_pkg;

    // Core-side widths
    localparam int LSU_THREAD_W = 5;
    localparam int LSU_REG_W    = 3;

    typedef logic [LSU_THREAD_W-1:0] lsu_thread_t;
    typedef logic [LSU_REG_W-1:0]    lsu_reg_t;

    // Request from the core
    typedef struct packed {
        lsu_thread_t          thread;
        logic                 wr;
        lsu_reg_t             reg_idx;
        ring_pkg::ring_mask_t mask;
        ring_pkg::ring_addr_t addr;
        ring_pkg::ring_data_t data;
    } lsu_req_t;

    // Load data handed back to the core register file
    typedef struct packed {
        lsu_thread_t          thread;
        lsu_reg_t             reg_idx;
        ring_pkg::ring_data_t data;
    } lsu_load_t;

    // What the tracker remembers about an outstanding request
    typedef struct packed {
        lsu_reg_t             reg_idx;
        ring_pkg::ring_mask_t mask;
        logic                 wr;
    } trk_entry_t;

endpackage

/* verilog/lsu_skid_buffer.sv */
`timescale 1ns/1ps

module lsu_skid_buffer #(
    parameter type T = logic [31:0]
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    logic skid_valid;
    T     skid_data;
    logic out_valid_d;
    logic skid_valid_d;
    logic load_out;
    logic load_skid;
    logic from_skid;
    logic in_fire;

    assign in_fire = in_valid && in_ready;

    always_comb
    begin
        out_valid_d  = out_valid;
        skid_valid_d = skid_valid;
        load_out     = 1'b0;
        load_skid    = 1'b0;
        from_skid    = 1'b0;
        if (!out_valid || out_ready)
        begin
            // Head is free or draining, refill from skid first
            if (skid_valid)
            begin
                out_valid_d  = 1'b1;
                skid_valid_d = 1'b0;
                from_skid    = 1'b1;
            end
            else
            begin
                out_valid_d = in_fire;
                load_out    = in_fire;
            end
        end
        else if (in_fire)
        begin
            // Head is stuck, park the new entry
            skid_valid_d = 1'b1;
            load_skid    = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end
        else
        begin
            out_valid  <= out_valid_d;
            skid_valid <= skid_valid_d;
            in_ready   <= !skid_valid_d;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_out)
            out_data <= in_data;
        else if (from_skid)
            out_data <= skid_data;
        if (load_skid)
            skid_data <= in_data;
    end

endmodule

/* verilog/lsu_tracker.sv */
`timescale 1ns/1ps

module lsu_tracker #(
    parameter int NUM_THREADS = 8
)
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  lsu_pkg::lsu_req_t      in_req,
    output logic                   tx_valid,
    input  logic                   tx_ready,
    output lsu_pkg::lsu_req_t      tx_req,
    input  logic                   rsp_valid,
    output logic                   rsp_ready,
    input  ring_pkg::ring_pkt_t    rsp,
    input  ring_pkg::ring_data_t   align_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output lsu_pkg::lsu_load_t     out_load,
    output logic [NUM_THREADS-1:0] stall
);
    import ring_pkg::*;
    import lsu_pkg::*;

    localparam int TID_W = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1;

    logic [NUM_THREADS-1:0] stall_q;
    trk_entry_t             entry_q [NUM_THREADS];
    logic [TID_W-1:0]       in_tid;
    logic [TID_W-1:0]       rsp_tid;
    logic [NUM_THREADS-1:0] head_bit;
    logic [NUM_THREADS-1:0] acc_bit;
    logic [NUM_THREADS-1:0] ret_bit;
    trk_entry_t             rsp_ent;
    ring_data_t             load_data;
    logic                   accept;
    logic                   retire;

    assign in_tid  = in_req.thread[TID_W-1:0];
    assign rsp_tid = rsp.tag[TID_W-1:0];

    // Issue side, one outstanding request per thread
    assign tx_valid = in_valid && !stall_q[in_tid];
    assign in_ready = tx_ready && !stall_q[in_tid];
    assign tx_req   = in_req;
    assign accept   = tx_valid && tx_ready;

    // A request waiting at the head already counts as stalled
    assign head_bit = in_valid ? (NUM_THREADS'(1) << in_tid) : '0;
    assign stall    = stall_q | head_bit;

    // Retire side
    // Writes always drain, reads wait for room in the load buffer
    assign rsp_ent   = entry_q[rsp_tid];
    assign rsp_ready = rsp_ent.wr || out_ready;
    assign out_valid = rsp_valid && !rsp_ent.wr;
    assign retire    = rsp_valid && rsp_ready;

    // Clamp to the lane width recorded at issue
    always_comb
    begin
        if (&rsp_ent.mask)
            load_data = align_data;
        else if (&rsp_ent.mask[3:2] || &rsp_ent.mask[1:0])
            load_data = {16'd0, align_data[15:0]};
        else
            load_data = {24'd0, align_data[7:0]};
    end

    assign out_load = '{thread: rsp.tag, reg_idx: rsp_ent.reg_idx, data: load_data};

    assign acc_bit = accept ? (NUM_THREADS'(1) << in_tid) : '0;
    assign ret_bit = retire ? (NUM_THREADS'(1) << rsp_tid) : '0;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            stall_q <= '0;
        else
            stall_q <= (stall_q & ~ret_bit) | acc_bit;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            entry_q[in_tid] <= '{reg_idx: in_req.reg_idx, mask: in_req.mask, wr: in_req.wr};
    end

endmodule

/* verilog/ring_lsu_top.sv */
`timescale 1ns/1ps

module ring_lsu_top #(
    parameter int NUM_THREADS = 8,
    parameter int MASTER_ID   = 0,
    parameter int MEM_WORDS   = 256
)
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  lsu_pkg::lsu_req_t      req,
    output logic                   load_valid,
    input  logic                   load_ready,
    output lsu_pkg::lsu_load_t     load,
    output logic [NUM_THREADS-1:0] stall
);
    import ring_pkg::*;
    import lsu_pkg::*;

    localparam int TID_W = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1;

    logic             req_gate;
    logic [TID_W-1:0] req_tid;
    logic             rq_in_valid;
    logic             rq_in_ready;
    logic             rq_valid;
    logic             rq_ready;
    lsu_req_t         rq_data;
    logic             tx_valid;
    logic             tx_ready;
    lsu_req_t         tx_req;
    ring_pkt_t        ring_m2s;
    ring_pkt_t        ring_s2m;
    logic             rsp_valid;
    logic             rsp_ready;
    ring_pkt_t        rsp;
    ring_data_t       aligned;
    logic             ld_valid;
    logic             ld_ready;
    lsu_load_t        ld_data;

    assign req_tid = req.thread[TID_W-1:0];

    // Admit a request only when it lands straight in the buffer head,
    // so its stall bit shows on the following cycle
    assign req_gate    = (!rq_valid || rq_ready) && !stall[req_tid];
    assign req_ready   = rq_in_ready && req_gate;
    assign rq_in_valid = req_valid && req_gate;

    lsu_skid_buffer #(.T(lsu_req_t)) u_req_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (rq_in_valid),
        .in_ready  (rq_in_ready),
        .in_data   (req),
        .out_valid (rq_valid),
        .out_ready (rq_ready),
        .out_data  (rq_data)
    );

    lsu_tracker #(.NUM_THREADS(NUM_THREADS)) u_tracker (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (rq_valid),
        .in_ready   (rq_ready),
        .in_req     (rq_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx_req     (tx_req),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp),
        .align_data (aligned),
        .out_valid  (ld_valid),
        .out_ready  (ld_ready),
        .out_load   (ld_data),
        .stall      (stall)
    );

    // Two-node loop: master feeds memory, memory feeds master
    ring_master_node #(.MASTER_ID(MASTER_ID)) u_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (tx_valid),
        .req_ready (tx_ready),
        .req       (tx_req),
        .ring_in   (ring_s2m),
        .ring_out  (ring_m2s),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    ring_memory_node #(.MEM_WORDS(MEM_WORDS)) u_memory (
        .clk      (clk),
        .rst_n    (rst_n),
        .ring_in  (ring_m2s),
        .ring_out (ring_s2m)
    );

    load_align u_align (
        .mask    (rsp.mask),
        .data    (rsp.data),
        .aligned (aligned)
    );

    lsu_skid_buffer #(.T(lsu_load_t)) u_load_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (ld_valid),
        .in_ready  (ld_ready),
        .in_data   (ld_data),
        .out_valid (load_valid),
        .out_ready (load_ready),
        .out_data  (load)
    );

endmodule

/* verilog/ring_master_node.sv */
`timescale 1ns/1ps

module ring_master_node #(
    parameter int MASTER_ID = 0
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    output logic                req_ready,
    input  lsu_pkg::lsu_req_t   req,
    input  ring_pkg::ring_pkt_t ring_in,
    output ring_pkg::ring_pkt_t ring_out,
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output ring_pkg::ring_pkt_t rsp
);
    import ring_pkg::*;

    localparam ring_id_t MY_ID = ring_id_t'(MASTER_ID);

    logic      pend_valid;
    ring_pkt_t pend;
    logic      own_rsp;
    logic      take;
    logic      slot_free;
    logic      insert;
    logic      req_fire;
    ring_pkt_t slot_d;

    // Responses for this master are offered straight off the ring input
    assign own_rsp   = ring_in.valid && ring_in.is_rsp && (ring_in.master_id == MY_ID);
    assign rsp_valid = own_rsp;
    assign rsp       = ring_in;
    assign take      = own_rsp && rsp_ready;

    // A slot freed by a taken response can carry the pending request
    assign slot_free = !ring_in.valid || take;
    assign insert    = pend_valid && slot_free;
    assign req_ready = !pend_valid || insert;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            pend_valid <= 1'b0;
        else if (req_fire)
            pend_valid <= 1'b1;
        else if (insert)
            pend_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (req_fire)
        begin
            pend <= '{valid:     1'b1,
                      is_rsp:    1'b0,
                      wr:        req.wr,
                      master_id: MY_ID,
                      tag:       req.thread,
                      mask:      req.mask,
                      addr:      req.addr,
                      data:      req.data};
        end
    end

    always_comb
    begin
        slot_d = ring_in;
        if (insert)
            slot_d = pend;
        else if (take)
            slot_d.valid = 1'b0;
    end

    // One cycle per hop
    always_ff @(posedge clk)
    begin
        ring_out <= slot_d;
        if (!rst_n)
            ring_out.valid <= 1'b0;
    end

endmodule

/* verilog/ring_memory_node.sv */
`timescale 1ns/1ps

module ring_memory_node #(
    parameter int MEM_WORDS = 256
)
(
    input  logic                clk,
    input  logic                rst_n,
    input  ring_pkg::ring_pkt_t ring_in,
    output ring_pkg::ring_pkt_t ring_out
);
    import ring_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    ring_data_t       mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             is_req;
    ring_data_t       stored;
    ring_data_t       merged;
    ring_pkt_t        slot_d;

    // Depth is a power of two, the low word-address bits give the wrap
    assign idx    = ring_in.addr[IDX_W-1:0];
    assign is_req = ring_in.valid && !ring_in.is_rsp;
    assign stored = mem[idx];

    // Byte merge for masked writes
    always_comb
    begin
        merged = stored;
        for (int b = 0; b < RING_BYTES; b++)
        begin
            if (ring_in.mask[b])
                merged[8*b +: 8] = ring_in.data[8*b +: 8];
        end
    end

    always_ff @(posedge clk)
    begin
        if (is_req && ring_in.wr)
            mem[idx] <= merged;
    end

    // Answer in the same slot
    // master_id, tag and mask ride back untouched
    always_comb
    begin
        slot_d = ring_in;
        if (is_req)
        begin
            slot_d.is_rsp = 1'b1;
            if (!ring_in.wr)
                slot_d.data = stored;
        end
    end

    always_ff @(posedge clk)
    begin
        ring_out <= slot_d;
        if (!rst_n)
            ring_out.valid <= 1'b0;
    end

endmodule

/* verilog/ring_pkg.sv */
package ring_pkg;

    // Ring-side field widths
    localparam int RING_ADDR_W = 24;
    localparam int RING_DATA_W = 32;
    localparam int RING_MASK_W = 4;
    localparam int RING_TAG_W  = 5;
    localparam int RING_ID_W   = 3;

    // One mask bit per byte lane
    localparam int RING_BYTES  = RING_MASK_W;

    typedef logic [RING_ADDR_W-1:0] ring_addr_t;
    typedef logic [RING_DATA_W-1:0] ring_data_t;
    typedef logic [RING_MASK_W-1:0] ring_mask_t;
    typedef logic [RING_TAG_W-1:0]  ring_tag_t;
    typedef logic [RING_ID_W-1:0]   ring_id_t;

    // A single ring slot
    // valid marks an occupied slot, is_rsp tells request from response
    typedef struct packed {
        logic       valid;
        logic       is_rsp;
        logic       wr;
        ring_id_t   master_id;
        ring_tag_t  tag;
        ring_mask_t mask;
        ring_addr_t addr;
        ring_data_t data;
    } ring_pkt_t;

endpackage
